// File: filelist.f
+incdir+common
common/tinyriscv_pkg.sv
apb4_rom/apb4_rom.sv
logic/apb_decoder.sv
logic/boot_ctrl.sv
logic/fetch_seq.sv
logic/imem_subsys.sv
sim/tb_imem_subsys.sv

// File: Bender.yml
package:
  name: imem_subsys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tinyriscv_pkg.sv
      - apb4_rom/apb4_rom.sv
      - logic/apb_decoder.sv
      - logic/boot_ctrl.sv
      - logic/fetch_seq.sv
      - logic/imem_subsys.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_imem_subsys.sv

// File: sim/tb_imem_subsys.sv
// instruction memory subsystem testbench
`include "tinyriscv_consts.svh"

module tb_imem_subsys
    import tinyriscv_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned ROM_BYTES = `TR_ROM_BYTES;
    localparam int unsigned TIMEOUT   = 200;   // cycles per wait

    logic   apb_if;
    logic   rst_n;
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    data_t  pwdata;
    strb_t  pstrb;
    data_t  prdata;
    logic   pready;
    logic   pslverr;
    logic   instr_valid;
    data_t  instr;
    pc_t    instr_pc;

    logic [7:0]  model_mem [ROM_BYTES];  // byte model of the memory
    logic [15:0] lfsr = 16'd65;          // galois state
    data_t       exp_rdata;
    logic        exp_err;
    logic        chk_exact;   // compare prdata with exp_rdata
    logic        chk_pc;      // prdata only has to be a window pc
    logic        fetch_off;   // strobes must be gone
    pc_t         exp_boot;
    int          err_count  = 0;
    int          test_count = 0;
    int          err_at_start;

    imem_subsys dut (.*);

    initial begin
        apb_if = 1'b0;
        forever #20 apb_if = ~apb_if;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic data_t model_word(input int unsigned byte_addr);
        int unsigned base;
        base = byte_addr & (ROM_BYTES - 4);  // word aligned, wraps
        return {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
    endfunction

    function automatic pc_t next_pc(input pc_t p);
        return pc_t'((32'(p) + 4) % ROM_BYTES);
    endfunction

    // address map rule, neither window hit
    function automatic logic is_unmapped(input paddr_t a);
        logic in_rom;
        logic in_ctrl;
        in_rom  = (a >= `TR_ROM_BASE) && (a < `TR_ROM_BASE + `TR_ROM_BYTES);
        in_ctrl = (a >= `TR_CTRL_BASE) && (a < `TR_CTRL_BASE + `TR_CTRL_BYTES);
        return !(in_rom || in_ctrl);
    endfunction

    task automatic flag_error(input string msg);
        err_count++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t: no response while waiting for %s", $time, what);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s finished with %0d errors", test_count, name,
                 err_count - err_at_start);
        err_at_start = err_count;
    endtask

    // waits for the completing edge, pready sampled at posedge
    task automatic wait_ready();
        int cycles;
        cycles = 0;
        @(posedge apb_if);
        while (!pready) begin
            cycles++;
            if (cycles >= TIMEOUT) timeout_fail("pready");
            @(posedge apb_if);
        end
    endtask

    task automatic apb_write(input paddr_t addr, input data_t data, input strb_t strb);
        @(negedge apb_if);
        psel    = 1'b1;      // setup
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        exp_err = is_unmapped(addr);
        @(negedge apb_if);
        penable = 1'b1;      // access
        wait_ready();
        if (addr < ROM_BYTES) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) model_mem[(addr & 16'hFFFC) + i] = data[i*8 +: 8];
            end
        end
        @(negedge apb_if);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input paddr_t addr, input data_t exp, input logic pc_range);
        @(negedge apb_if);
        psel      = 1'b1;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = addr;
        exp_err   = is_unmapped(addr);
        exp_rdata = exp;
        chk_exact = !pc_range;
        chk_pc    = pc_range;
        @(negedge apb_if);
        penable = 1'b1;
        wait_ready();
        @(negedge apb_if);
        psel      = 1'b0;
        penable   = 1'b0;
        chk_exact = 1'b0;
        chk_pc    = 1'b0;
    endtask

    // counts strobes, sampled at negedge
    task automatic wait_strobes(input int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n) begin
            @(negedge apb_if);
            cycles++;
            if (instr_valid) seen++;
            if (cycles >= TIMEOUT) timeout_fail("instruction strobes");
        end
    endtask

    // clears run, strobes gone two edges after the write
    task automatic stop_fetch();
        apb_write(`TR_CTRL_BASE + `TR_REG_CTRL, 32'd0, 4'hF);
        repeat (2) @(posedge apb_if);
        @(negedge apb_if);
        fetch_off = 1'b1;
        repeat (6) @(negedge apb_if);  // observe it stays low
    endtask

    a_read_data: assert property (@(posedge apb_if) disable iff (!rst_n)
        (psel && penable && !pwrite && chk_exact) |-> (prdata == exp_rdata))
        else flag_error($sformatf("prdata %h, expected %h", $sampled(prdata), exp_rdata));

    a_read_pc: assert property (@(posedge apb_if) disable iff (!rst_n)
        (psel && penable && !pwrite && chk_pc) |->
            (prdata < ROM_BYTES && prdata[1:0] == 2'b00))
        else flag_error($sformatf("pc read %h outside the window", $sampled(prdata)));

    a_slverr: assert property (@(posedge apb_if) disable iff (!rst_n)
        (psel && penable) |-> (pslverr == exp_err))
        else flag_error($sformatf("pslverr %b, expected %b", $sampled(pslverr), exp_err));

    a_instr_word: assert property (@(posedge apb_if) disable iff (!rst_n)
        instr_valid |-> (instr == model_word(instr_pc)))
        else flag_error($sformatf("instr %h at pc %h differs from the model",
                                  $sampled(instr), $sampled(instr_pc)));

    a_instr_first: assert property (@(posedge apb_if) disable iff (!rst_n)
        (instr_valid && !$past(instr_valid)) |-> (instr_pc == exp_boot))
        else flag_error($sformatf("first pc %h, expected boot %h", $sampled(instr_pc), exp_boot));

    a_instr_step: assert property (@(posedge apb_if) disable iff (!rst_n)
        (instr_valid && $past(instr_valid)) |-> (instr_pc == next_pc($past(instr_pc))))
        else flag_error($sformatf("pc %h did not step by 4", $sampled(instr_pc)));

    a_fetch_off: assert property (@(posedge apb_if) disable iff (!rst_n)
        fetch_off |-> !instr_valid)
        else flag_error("instr_valid still high after run was cleared");

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] s;
        paddr_t      a;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        exp_rdata = '0;
        exp_err   = 1'b0;
        chk_exact = 1'b0;
        chk_pc    = 1'b0;
        fetch_off = 1'b0;
        exp_boot  = '0;
        err_at_start = 0;
        repeat (8) @(posedge apb_if);
        @(negedge apb_if);
        rst_n = 1'b1;

        for (int i = 0; i < 16; i++) begin    // full word writes
            draw_bits(11, r);
            draw_bits(32, d);
            a = paddr_t'(r << 2);
            apb_write(a, d, 4'hF);
            apb_read(a, model_word(a), 1'b0);
        end
        end_test("full word write and read");

        for (int i = 0; i < 8; i++) begin     // byte strobe merge
            draw_bits(11, r);
            draw_bits(32, d);
            apb_write(paddr_t'(r << 2), d, 4'hF);
            draw_bits(32, d);
            draw_bits(4, s);
            apb_write(paddr_t'(r << 2), d, strb_t'(s));
            apb_read(paddr_t'(r << 2), model_word(r << 2), 1'b0);
        end
        end_test("byte strobes");

        apb_write(16'h1000, 32'h1357_9BDF, 4'hF);   // 0x3000 would alias here
        apb_write(16'h3000, 32'hDEAD_BEEF, 4'hF);
        apb_read(16'h3000, 32'd0, 1'b0);
        apb_write(16'h2010, 32'd1, 4'hF);           // would alias CTRL
        apb_read(16'h2010, 32'd0, 1'b0);
        apb_read(16'h1000, model_word(16'h1000), 1'b0);
        apb_read(`TR_CTRL_BASE + `TR_REG_CTRL, 32'd0, 1'b0);
        apb_read(`TR_CTRL_BASE + `TR_REG_BOOT, 32'd0, 1'b0);
        end_test("unmapped access");

        apb_write(`TR_CTRL_BASE + `TR_REG_BOOT, 32'h0000_0123, 4'hF);
        apb_read(`TR_CTRL_BASE + `TR_REG_BOOT, 32'h0000_0120, 1'b0);   // low bits cleared
        apb_read(`TR_CTRL_BASE + `TR_REG_CTRL, 32'd0, 1'b0);
        apb_write(`TR_CTRL_BASE + `TR_REG_PC, 32'h0000_ABCC, 4'hF);    // read only
        apb_read(`TR_CTRL_BASE + `TR_REG_PC, 32'd0, 1'b0);
        end_test("register block");

        for (int i = 0; i < 32; i++) begin    // program at 0x400
            draw_bits(32, d);
            apb_write(paddr_t'(16'h0400 + 4 * i), d, 4'hF);
        end
        exp_boot = 16'h0400;
        apb_write(`TR_CTRL_BASE + `TR_REG_BOOT, 32'(exp_boot), 4'hF);
        apb_write(`TR_CTRL_BASE + `TR_REG_CTRL, 32'd1, 4'hF);
        apb_read(`TR_CTRL_BASE + `TR_REG_CTRL, 32'd1, 1'b0);
        apb_read(`TR_CTRL_BASE + `TR_REG_PC, 32'd0, 1'b1);
        wait_strobes(10);
        end_test("fetch stream");

        stop_fetch();
        fetch_off = 1'b0;
        apb_write(`TR_CTRL_BASE + `TR_REG_CTRL, 32'd1, 4'hF);   // resume from boot
        wait_strobes(4);
        stop_fetch();
        end_test("fetch stop and restart");

        $display("tests run: %0d, errors: %0d", test_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: logic/imem_subsys.sv
// instruction memory subsystem top
module imem_subsys
    import tinyriscv_pkg::*;
(
    input  logic   apb_if,       // clock
    input  logic   rst_n,
    input  logic   psel,
    input  logic   penable,
    input  logic   pwrite,
    input  paddr_t paddr,
    input  data_t  pwdata,
    input  strb_t  pstrb,
    output data_t  prdata,
    output logic   pready,
    output logic   pslverr,
    output logic   instr_valid,
    output data_t  instr,
    output pc_t    instr_pc
);

    // decoder to slaves
    logic  rom_sel;
    logic  ctrl_sel;
    data_t rom_rdata;
    data_t ctrl_rdata;

    // control and fetch path
    logic  run;
    pc_t   boot_addr;
    pc_t   fetch_pc;    // status back to the registers
    pc_t   fetch_addr;
    data_t fetch_data;

    apb_decoder u_decoder (
        .psel       (psel),
        .paddr      (paddr),
        .penable    (penable),
        .rom_rdata  (rom_rdata),
        .ctrl_rdata (ctrl_rdata),
        .rom_sel    (rom_sel),
        .ctrl_sel   (ctrl_sel),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    apb4_rom u_rom (
        .apb_if     (apb_if),
        .rst_n      (rst_n),
        .sel        (rom_sel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pstrb      (pstrb),
        .fetch_addr (fetch_addr),
        .rdata      (rom_rdata),
        .fetch_data (fetch_data)
    );

    // register block ignores pstrb, full word writes only
    boot_ctrl u_boot_ctrl (
        .apb_if    (apb_if),
        .rst_n     (rst_n),
        .sel       (ctrl_sel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .fetch_pc  (fetch_pc),
        .rdata     (ctrl_rdata),
        .run       (run),
        .boot_addr (boot_addr)
    );

    fetch_seq u_fetch (
        .apb_if      (apb_if),
        .rst_n       (rst_n),
        .run         (run),
        .boot_addr   (boot_addr),
        .fetch_data  (fetch_data),
        .fetch_addr  (fetch_addr),
        .fetch_pc    (fetch_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

endmodule

// File: logic/fetch_seq.sv
// sequential instruction fetch
module fetch_seq
    import tinyriscv_pkg::*;
(
    input  logic  apb_if,       // clock
    input  logic  rst_n,
    input  logic  run,
    input  pc_t   boot_addr,
    input  data_t fetch_data,   // same cycle read of fetch_addr
    output pc_t   fetch_addr,
    output pc_t   fetch_pc,
    output logic  instr_valid,
    output data_t instr,
    output pc_t   instr_pc
);

    localparam int unsigned IDX_HI = $bits(word_addr_t) + 1;  // top bit of the word index

    fetch_state_t state;
    pc_t          pc;    // address presented to the memory

    // next word, wraps inside the memory window
    function automatic pc_t step_pc(input pc_t cur);
        word_addr_t idx;
        idx = cur[IDX_HI:2] + 1'b1;
        return pc_t'({idx, 2'b00});
    endfunction

    assign fetch_addr = pc;
    assign fetch_pc   = pc;

    // control state and pc
    always_ff @(posedge apb_if or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FETCH_IDLE;
            pc          <= '0;
            instr_valid <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    instr_valid <= 1'b0;
                    if (run) begin
                        pc    <= pc_t'({boot_addr[IDX_HI:2], 2'b00});  // window aligned
                        state <= FETCH_RUN;
                    end
                end
                FETCH_RUN: begin
                    if (run) begin
                        instr_valid <= 1'b1;       // one strobe per cycle
                        pc          <= step_pc(pc);
                    end else begin
                        instr_valid <= 1'b0;
                        state       <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // output register, word and its pc
    always_ff @(posedge apb_if) begin
        if (state == FETCH_RUN && run) begin
            instr    <= fetch_data;
            instr_pc <= pc;
        end
    end

    a_instr_aligned: assert property (
        @(posedge apb_if) disable iff (!rst_n)
        instr_valid |-> (instr_pc[1:0] == 2'b00)
    ) else $error("fetch_seq emitted an unaligned pc");

endmodule

// File: logic/boot_ctrl.sv
// boot and run control registers
`include "tinyriscv_consts.svh"

module boot_ctrl
    import tinyriscv_pkg::*;
(
    input  logic   apb_if,     // clock
    input  logic   rst_n,
    input  logic   sel,        // select from the decoder
    input  logic   penable,
    input  logic   pwrite,
    input  paddr_t paddr,
    input  data_t  pwdata,
    input  pc_t    fetch_pc,   // live pc for the status read
    output data_t  rdata,
    output logic   run,
    output pc_t    boot_addr
);

    // offset bits inside the register window
    localparam int unsigned OFS_W = $clog2(`TR_CTRL_BYTES);

    localparam logic [OFS_W-1:0] OFS_CTRL = OFS_W'(`TR_REG_CTRL);
    localparam logic [OFS_W-1:0] OFS_BOOT = OFS_W'(`TR_REG_BOOT);
    localparam logic [OFS_W-1:0] OFS_PC   = OFS_W'(`TR_REG_PC);

    logic [OFS_W-1:0] reg_ofs;
    logic             wr_en;    // write completes this cycle

    assign reg_ofs = paddr[OFS_W-1:0];
    assign wr_en   = sel && penable && pwrite;

    // register updates
    always_ff @(posedge apb_if or negedge rst_n) begin
        if (!rst_n) begin
            run       <= 1'b0;
            boot_addr <= '0;
        end else if (wr_en) begin
            case (reg_ofs)
                OFS_CTRL: begin
                    run <= pwdata[0];
                end
                OFS_BOOT: begin
                    // keep the boot address word aligned
                    boot_addr <= {pwdata[$bits(pc_t)-1:2], 2'b00};
                end
                default: begin
                    // pc is read only, other offsets unused
                end
            endcase
        end
    end

    // combinational read, valid for the whole access cycle
    always_comb begin
        rdata = '0;
        if (sel) begin
            case (reg_ofs)
                OFS_CTRL: rdata = data_t'(run);
                OFS_BOOT: rdata = data_t'(boot_addr);
                OFS_PC:   rdata = data_t'(fetch_pc);   // zero extended
                default:  rdata = '0;
            endcase
        end
    end

endmodule

// File: logic/apb_decoder.sv
// APB address decoder
`include "tinyriscv_consts.svh"

module apb_decoder
    import tinyriscv_pkg::*;
(
    input  logic   psel,
    input  paddr_t paddr,
    input  logic   penable,
    input  data_t  rom_rdata,
    input  data_t  ctrl_rdata,
    output logic   rom_sel,
    output logic   ctrl_sel,
    output data_t  prdata,
    output logic   pready,
    output logic   pslverr
);

    // window bounds, upper bound exclusive
    localparam int unsigned ROM_LO  = `TR_ROM_BASE;
    localparam int unsigned ROM_HI  = `TR_ROM_BASE + `TR_ROM_BYTES;
    localparam int unsigned CTRL_LO = `TR_CTRL_BASE;
    localparam int unsigned CTRL_HI = `TR_CTRL_BASE + `TR_CTRL_BYTES;

    logic [31:0] addr_ext;  // widened for the compares
    logic        rom_hit;
    logic        ctrl_hit;
    logic        miss;      // no window matches

    assign addr_ext = 32'(paddr);

    assign rom_hit  = (addr_ext >= ROM_LO) && (addr_ext < ROM_HI);
    assign ctrl_hit = (addr_ext >= CTRL_LO) && (addr_ext < CTRL_HI);
    assign miss     = !rom_hit && !ctrl_hit;

    // select fan-out, follows psel
    assign rom_sel  = psel && rom_hit;
    assign ctrl_sel = psel && ctrl_hit;

    // read data back from whichever slave is selected
    always_comb begin
        if (rom_sel) begin
            prdata = rom_rdata;
        end else if (ctrl_sel) begin
            prdata = ctrl_rdata;
        end else begin
            prdata = '0;   // unmapped or idle
        end
    end

    assign pready  = 1'b1;                     // every slave is zero wait
    assign pslverr = psel && penable && miss;  // error only in the access cycle

    // windows must not overlap
    always_comb begin
        a_one_hot_sel: assert #0 (!(rom_sel && ctrl_sel))
            else $error("apb_decoder selected both slaves");
    end

endmodule

// File: apb4_rom/apb4_rom.sv
// APB4 program memory
`include "tinyriscv_consts.svh"

module apb4_rom
    import tinyriscv_pkg::*;
(
    input  logic   apb_if,      // clock
    input  logic   rst_n,
    input  logic   sel,         // select from the decoder
    input  logic   penable,
    input  logic   pwrite,
    input  paddr_t paddr,
    input  data_t  pwdata,
    input  strb_t  pstrb,
    input  pc_t    fetch_addr,  // byte address from the fetch sequencer
    output data_t  rdata,
    output data_t  fetch_data
);

    // depth from the window size
    localparam int unsigned LANES     = $bits(data_t) / 8;
    localparam int unsigned ROM_WORDS = `TR_ROM_BYTES / LANES;
    localparam int unsigned IDX_LO    = $clog2(LANES);            // byte offset bits
    localparam int unsigned IDX_HI    = IDX_LO + $bits(word_addr_t) - 1;

    data_t mem [ROM_WORDS];  // no init, contents undefined until loaded

    word_addr_t bus_idx;    // word addressed by apb
    word_addr_t fetch_idx;  // word addressed by the fetch port
    logic       wr_access;  // access phase of a write
    logic       rd_setup;   // setup phase of a read

    assign bus_idx   = paddr[IDX_HI:IDX_LO];
    assign fetch_idx = fetch_addr[IDX_HI:IDX_LO];

    assign wr_access = sel && penable && pwrite;   // zero wait, completes here
    assign rd_setup  = sel && !penable && !pwrite;

    // byte lane writes
    always_ff @(posedge apb_if) begin
        if (wr_access) begin
            for (int i = 0; i < LANES; i++) begin
                if (pstrb[i]) begin
                    mem[bus_idx][i*8 +: 8] <= pwdata[i*8 +: 8];
                end
            end
        end
    end

    // read data captured at the edge ending setup
    // so it is stable for the whole access cycle
    always_ff @(posedge apb_if) begin
        if (rd_setup) begin
            rdata <= mem[bus_idx];
        end
    end

    // second read port, combinational for the fetch sequencer
    always_comb begin
        if (!rst_n) begin
            fetch_data = '0;                // quiet while in reset
        end else begin
            fetch_data = mem[fetch_idx];
        end
    end

    // every access to this slave must follow a setup cycle
    // with the same select, otherwise rdata was never loaded
    a_setup_before_access: assert property (
        @(posedge apb_if) disable iff (!rst_n)
        (sel && penable) |-> $past(sel && !penable)
    ) else $error("apb4_rom access without a setup cycle");

endmodule

// File: common/tinyriscv_pkg.sv
// tinyriscv shared types
package tinyriscv_pkg;

    // apb byte address
    typedef logic [15:0] paddr_t;

    // bus and instruction word
    typedef logic [31:0] data_t;

    // one strobe per byte lane
    typedef logic [3:0] strb_t;

    // word index into the 2048 word memory
    typedef logic [10:0] word_addr_t;

    // fetch program counter, byte address
    typedef logic [15:0] pc_t;

    // fetch sequencer states
    typedef enum logic {
        FETCH_IDLE = 1'b0,  // waiting for run
        FETCH_RUN  = 1'b1   // streaming one word per cycle
    } fetch_state_t;

endpackage

// File: common/tinyriscv_consts.svh
// tinyriscv address map constants
`ifndef TINYRISCV_CONSTS_SVH
`define TINYRISCV_CONSTS_SVH

// program memory window
`define TR_ROM_BASE   'h0000
`define TR_ROM_BYTES  8192     // 2048 words of 32 bits

// register block window
`define TR_CTRL_BASE  'h2000
`define TR_CTRL_BYTES 16

// register offsets inside the register block
`define TR_REG_CTRL   'h0      // bit 0 is run
`define TR_REG_BOOT   'h4      // boot address, word aligned
`define TR_REG_PC     'h8      // live fetch pc, read only

`endif
